// File: exu.f
+incdir+hw
hw/exu_pkg.sv
hw/int_alu.sv
hw/seq_mul.sv
hw/seq_div.sv
hw/exu_top.sv
verification/exu_sva.sv
verification/exu_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f exu.f --top-module exu_tb \
  || { echo "build failed"; exit 1; }
./obj_dir/Vexu_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

// File: verification/exu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_cfg.svh"

module exu_tb import exu_pkg::*; ();

  localparam int XLEN          = `EXU_XLEN;
  localparam int SHW           = $clog2(XLEN);
  localparam int N_M_OPS       = 40 + 40 + 6 + 2;
  localparam int N_ALU_OPS     = 240 + N_M_OPS;
  localparam int CYCLE_LIMIT   = N_ALU_OPS + N_M_OPS * (`EXU_MD_STEPS + 8);
  localparam logic [31:0] LFSR_SEED = 32'hc153cbfa;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic            clk;
  logic            rst_n;
  exu_ctrl_u       ctrl;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic            md_en;
  logic            flush;
  logic [XLEN-1:0] result;
  alu_flags_t      flags;
  logic            busy;

  logic [31:0]     lfsr_state;
  int              cycle_cnt = 0;
  int              n_res_errs = 0;
  int              n_flag_errs = 0;
  int              n_proto_errs = 0;

  exu_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl_i   (ctrl),
    .src1_i   (src1),
    .src2_i   (src2),
    .md_en_i  (md_en),
    .flush_i  (flush),
    .result_o (result),
    .flags_o  (flags),
    .busy_o   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
      end
    end
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] sext32(input logic [XLEN-1:0] v);
    return {{(XLEN-32){v[31]}}, v[31:0]};
  endfunction

  function automatic md_ctrl_t make_md_ctrl(input logic word, input logic is_div,
                                            input logic [1:0] md_type);
    md_ctrl_t c;
    c.word    = word;
    c.is_div  = is_div;
    c.md_type = md_type;
    c.rsvd    = 1'b0;
    return c;
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input alu_ctrl_t c, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    int unsigned     sh;
    sh = c.word ? b[4:0] : b[SHW-1:0];
    r  = '0;
    case (c.func)
      FUNC_ADD:  r = c.alt ? a - b : a + b;
      FUNC_SLL:  r = a << sh;
      FUNC_SLT: begin
        if (c.alt) r[0] = (a < b);
        else r[0] = ($signed(a) < $signed(b));
      end
      FUNC_PASS: r = b;
      FUNC_XOR:  r = a ^ b;
      FUNC_SR: begin
        // arithmetic word shifts fill from bit 31
        if (c.word && c.alt) r = $signed(sext32(a)) >>> sh;
        else if (c.word) r = {{(XLEN-32){1'b0}}, a[31:0]} >> sh;
        else if (c.alt) r = $signed(a) >>> sh;
        else r = a >> sh;
      end
      FUNC_OR:   r = a | b;
      default:   r = a & b;
    endcase
    return c.word ? sext32(r) : r;
  endfunction

  function automatic alu_flags_t flags_model(input alu_ctrl_t c, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
    alu_flags_t           f;
    logic signed [XLEN:0] wide_sum;
    if (c.alt) begin
      f.zero = (a == b);
      f.less = (a < b);
    end else if (c.func == FUNC_SLT) begin
      f.zero = (a == b);
      f.less = ($signed(a) < $signed(b));
    end else begin
      // less is the sign of the exact sum for a plain add
      wide_sum = $signed({a[XLEN-1], a}) + $signed({b[XLEN-1], b});
      f.zero   = ((a + b) == '0);
      f.less   = (wide_sum < 0);
    end
    return f;
  endfunction

  function automatic logic [XLEN-1:0] md_model(input md_ctrl_t c, input logic [XLEN-1:0] a_in,
                                               input logic [XLEN-1:0] b_in);
    logic              s1;
    logic              s2;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   r;
    logic [2*XLEN-1:0] pa;
    logic [2*XLEN-1:0] pb;
    logic [2*XLEN-1:0] prod;
    case ({c.is_div, c.md_type})
      3'b000, 3'b001, 3'b100, 3'b110: begin
        s1 = 1'b1;
        s2 = 1'b1;
      end
      3'b010: begin
        s1 = 1'b1;
        s2 = 1'b0;
      end
      default: begin
        s1 = 1'b0;
        s2 = 1'b0;
      end
    endcase
    a = a_in;
    b = b_in;
    if (c.word) begin
      a = s1 ? sext32(a_in) : {{(XLEN-32){1'b0}}, a_in[31:0]};
      b = s2 ? sext32(b_in) : {{(XLEN-32){1'b0}}, b_in[31:0]};
    end
    if (!c.is_div) begin
      pa   = s1 ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
      pb   = s2 ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
      prod = pa * pb;
      r    = (c.md_type == 2'b00) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    end else if (b == '0) begin
      r = c.md_type[1] ? a : '1;
    end else if (s1 && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
      r = c.md_type[1] ? '0 : a;
    end else if (s1) begin
      r = c.md_type[1] ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    end else begin
      r = c.md_type[1] ? a % b : a / b;
    end
    return c.word ? sext32(r) : r;
  endfunction

  task automatic check_result(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act,
                              input string name);
    if (act !== exp) begin
      n_res_errs++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flags(input alu_flags_t exp, input alu_flags_t act);
    if (act !== exp) begin
      n_flag_errs++;
      $display("FAIL %0t flags_o expected %b got %b", $time, exp, act);
    end
  endtask

  task automatic alu_op(input alu_ctrl_t c, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    @(negedge clk);
    ctrl.alu = c;
    src1     = a;
    src2     = b;
    md_en    = 1'b0;
    #1;
    check_result(alu_model(c, a, b), result, "result_o");
    check_flags(flags_model(c, a, b), flags);
    if (busy) begin
      n_proto_errs++;
      $display("busy_o is high during an ALU operation at %0t", $time);
    end
  endtask

  task automatic rand_alu_op();
    alu_ctrl_t   c;
    logic [63:0] r;
    r = rand_bits(5);
    c = r[4:0];
    alu_op(c, rand_bits(XLEN), rand_bits(XLEN));
  endtask

  task automatic md_op(input md_ctrl_t c, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [XLEN-1:0] exp;
    int              n_wait;
    exp    = md_model(c, a, b);
    n_wait = 0;
    @(negedge clk);
    ctrl.md = c;
    src1    = a;
    src2    = b;
    md_en   = 1'b1;
    #1;
    if (!busy) begin
      n_proto_errs++;
      $display("busy_o did not rise in the first cycle of an M operation at %0t", $time);
    end
    do begin
      @(negedge clk);
      #1;
      n_wait++;
    end while (busy);
    // done comes STEPS+1 cycles after start and the capture adds one
    if (n_wait != `EXU_MD_STEPS + 2) begin
      n_proto_errs++;
      $display("M operation took %0d cycles instead of %0d", n_wait, `EXU_MD_STEPS + 2);
    end
    check_result(exp, result, "result_o");
    @(negedge clk);
    #1;
    if (busy) begin
      n_proto_errs++;
      $display("busy_o rose again while the result was held at %0t", $time);
    end
    check_result(exp, result, "result_o held");
    rand_alu_op();
  endtask

  task automatic flush_mid_op();
    md_ctrl_t c;
    c = make_md_ctrl(1'b0, 1'b0, 2'b01);
    @(negedge clk);
    ctrl.md = c;
    src1    = rand_bits(XLEN);
    src2    = rand_bits(XLEN);
    md_en   = 1'b1;
    repeat (10) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    #1;
    if (busy) begin
      n_proto_errs++;
      $display("busy_o still high after a flush at %0t", $time);
    end
    @(negedge clk);
    md_en = 1'b0;
    md_op(c, rand_bits(XLEN), rand_bits(XLEN));
  endtask

  initial begin
    alu_ctrl_t       ac;
    logic [63:0]     r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              n_sva;
    lfsr_state = LFSR_SEED;
    rst_n      = 1'b0;
    ctrl       = '0;
    src1       = '0;
    src2       = '0;
    md_en      = 1'b0;
    flush      = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // cycle through every func, alt and word combination
    for (int i = 0; i < 200; i++) begin
      ac = i[4:0];
      alu_op(ac, rand_bits(XLEN), rand_bits(XLEN));
    end
    for (int i = 0; i < 20; i++) begin
      r  = rand_bits(2);
      ac = '{word: r[0], alt: r[1], func: FUNC_SLT};
      alu_op(ac, rand_bits(XLEN), rand_bits(XLEN));
    end
    // equal operands through sub and slt
    for (int i = 0; i < 10; i++) begin
      a  = rand_bits(XLEN);
      ac = '{word: i[0], alt: i[1] | ~i[2], func: i[2] ? FUNC_SLT : FUNC_ADD};
      alu_op(ac, a, a);
    end
    // operands of differing sign
    for (int i = 0; i < 10; i++) begin
      r  = rand_bits(XLEN - 1);
      a  = {1'b1, r[XLEN-2:0]};
      r  = rand_bits(XLEN - 1);
      b  = {1'b0, r[XLEN-2:0]};
      ac = '{word: 1'b0, alt: i[0], func: FUNC_SLT};
      if (i[1]) alu_op(ac, a, b);
      else alu_op(ac, b, a);
    end

    for (int i = 0; i < 40; i++) begin
      r = rand_bits(3);
      md_op(make_md_ctrl(r[0], 1'b0, r[2:1]), rand_bits(XLEN), rand_bits(XLEN));
    end
    for (int i = 0; i < 40; i++) begin
      r = rand_bits(3);
      md_op(make_md_ctrl(r[0], 1'b1, r[2:1]), rand_bits(XLEN), rand_bits(XLEN));
    end

    // divide by zero and signed overflow
    r = rand_bits(XLEN);
    md_op(make_md_ctrl(1'b0, 1'b1, 2'b01), rand_bits(XLEN), '0);
    md_op(make_md_ctrl(1'b1, 1'b1, 2'b10), rand_bits(XLEN), {r[31:0], 32'h0});
    md_op(make_md_ctrl(1'b0, 1'b1, 2'b00), {1'b1, {(XLEN-1){1'b0}}}, '1);
    md_op(make_md_ctrl(1'b0, 1'b1, 2'b10), {1'b1, {(XLEN-1){1'b0}}}, '1);
    md_op(make_md_ctrl(1'b1, 1'b1, 2'b00), {r[63:32], 32'h80000000}, {r[31:0], 32'hffffffff});
    md_op(make_md_ctrl(1'b1, 1'b1, 2'b10), {r[31:0], 32'h80000000}, {r[63:32], 32'hffffffff});

    flush_mid_op();

    n_sva = dut_i.sva_i.fail_cnt;
    $display("errors: result %0d, flags %0d, protocol %0d, assertion %0d",
             n_res_errs, n_flag_errs, n_proto_errs, n_sva);
    if (n_res_errs + n_flag_errs + n_proto_errs + n_sva == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/exu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module exu_sva (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic md_en_i,
  input wire logic flush_i,
  input wire logic busy_i,
  input wire logic mul_done_i,
  input wire logic div_done_i
);

  int unsigned fail_cnt = 0;

  // busy from the first cycle of an M request
  busy_start_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(md_en_i) |-> busy_i)
  else begin
    fail_cnt++;
    $error("busy_o low in the first cycle of md_en_i");
  end

  // only one engine runs at a time
  done_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
    !($rose(mul_done_i) && $rose(div_done_i)))
  else begin
    fail_cnt++;
    $error("multiplier and divider done pulses rose together");
  end

  flush_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> !busy_i)
  else begin
    fail_cnt++;
    $error("busy_o still high one cycle after flush_i");
  end

endmodule

bind exu_top exu_sva sva_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .md_en_i    (md_en_i),
  .flush_i    (flush_i),
  .busy_i     (busy_o),
  .mul_done_i (mul_done),
  .div_done_i (div_done)
);

`default_nettype wire

// File: hw/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_cfg.svh"

module exu_top import exu_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire exu_ctrl_u            ctrl_i,
  input  wire logic [`EXU_XLEN-1:0] src1_i,
  input  wire logic [`EXU_XLEN-1:0] src2_i,
  input  wire logic                 md_en_i,
  input  wire logic                 flush_i,
  output logic [`EXU_XLEN-1:0]      result_o,
  output alu_flags_t                flags_o,
  output logic                      busy_o
);

  localparam int XLEN = `EXU_XLEN;

  md_ctrl_t        md_ctrl;
  logic            op1_sgn;
  logic            op2_sgn;
  logic [XLEN-1:0] op1_ext;
  logic [XLEN-1:0] op2_ext;
  md_req_t         md_req;
  logic            md_en_q;
  logic            req_q;
  logic            res_vld_q;
  logic [XLEN-1:0] res_q;
  logic            start;
  logic            mul_start;
  logic            div_start;
  logic            mul_done;
  logic            div_done;
  logic [XLEN-1:0] mul_res;
  logic [XLEN-1:0] div_res;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] md_out;

  assign md_ctrl = ctrl_i.md;

  // per-operand signedness for the word-form extension
  always_comb begin
    if (md_ctrl.is_div) begin
      op1_sgn = ~md_ctrl.md_type[0];
      op2_sgn = ~md_ctrl.md_type[0];
    end else begin
      op1_sgn = (md_ctrl.md_type != MUL_HUU);
      op2_sgn = ~md_ctrl.md_type[1];
    end
  end

  assign op1_ext = md_ctrl.word ? {{(XLEN-32){op1_sgn & src1_i[31]}}, src1_i[31:0]} : src1_i;
  assign op2_ext = md_ctrl.word ? {{(XLEN-32){op2_sgn & src2_i[31]}}, src2_i[31:0]} : src2_i;
  assign md_req  = '{op1: op1_ext, op2: op2_ext, md_type: md_ctrl.md_type};

  // a new M operation starts on the rising edge of md_en_i
  assign start     = md_en_i & ~md_en_q;
  assign mul_start = start & ~md_ctrl.is_div;
  assign div_start = start & md_ctrl.is_div;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      md_en_q   <= 1'b0;
      req_q     <= 1'b0;
      res_vld_q <= 1'b0;
    end else begin
      md_en_q <= md_en_i;
      if (flush_i) begin
        req_q     <= 1'b0;
        res_vld_q <= 1'b0;
      end else if (start) begin
        req_q     <= 1'b1;
        res_vld_q <= 1'b0;
      end else if (req_q && (mul_done || div_done)) begin
        req_q     <= 1'b0;
        res_vld_q <= 1'b1;
      end else if (!md_en_i) begin
        res_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_q && (mul_done || div_done)) begin
      res_q <= div_done ? div_res : mul_res;
    end
  end

  int_alu u_alu (
    .ctrl_i   (ctrl_i.alu),
    .src1_i   (src1_i),
    .src2_i   (src2_i),
    .result_o (alu_res),
    .flags_o  (flags_o)
  );

  seq_mul u_mul (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_i  (flush_i),
    .start_i  (mul_start),
    .req_i    (md_req),
    .done_o   (mul_done),
    .result_o (mul_res)
  );

  seq_div u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_i  (flush_i),
    .start_i  (div_start),
    .req_i    (md_req),
    .done_o   (div_done),
    .result_o (div_res)
  );

  // busy from the first md_en_i cycle until a result is captured
  assign busy_o = md_en_i & ~res_vld_q & (start | req_q);

  assign md_out   = md_ctrl.word ? {{(XLEN-32){res_q[31]}}, res_q[31:0]} : res_q;
  assign result_o = md_en_i ? md_out : alu_res;

endmodule

`default_nettype wire

// File: hw/seq_div.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_cfg.svh"

module seq_div import exu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            flush_i,
  input  wire logic            start_i,
  input  wire md_req_t         req_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] result_o
);

  localparam int XLEN  = `EXU_XLEN;
  localparam int STEPS = `EXU_MD_STEPS;
  localparam int CW    = $clog2(STEPS + 1);

  logic            sgn;
  logic            n_neg;
  logic            d_neg;
  logic [XLEN-1:0] mag_n;
  logic [XLEN-1:0] mag_d;
  logic            run_q;
  logic            done_q;
  logic [CW-1:0]   cnt_q;
  logic [XLEN-1:0] rem_q;
  logic [XLEN-1:0] quo_q;
  logic [XLEN-1:0] dvs_q;
  logic [XLEN-1:0] dvd_q;
  logic            q_neg_q;
  logic            r_neg_q;
  logic            zero_q;
  logic            ovf_q;
  logic            rem_sel_q;
  logic [XLEN:0]   part;
  logic [XLEN+1:0] diff;
  logic            borrow;
  logic [XLEN-1:0] q_fix;
  logic [XLEN-1:0] r_fix;

  // odd md_type values are the unsigned forms
  assign sgn   = ~req_i.md_type[0];
  assign n_neg = sgn & req_i.op1[XLEN-1];
  assign d_neg = sgn & req_i.op2[XLEN-1];
  assign mag_n = n_neg ? -req_i.op1 : req_i.op1;
  assign mag_d = d_neg ? -req_i.op2 : req_i.op2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      run_q  <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (run_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CW'(STEPS - 1)) begin
        run_q  <= 1'b0;
        done_q <= 1'b1;
      end
    end else begin
      done_q <= 1'b0;
    end
  end

  // trial subtract of the divisor from the shifted partial remainder
  assign part   = {rem_q, quo_q[XLEN-1]};
  assign diff   = {1'b0, part} - {2'b00, dvs_q};
  assign borrow = diff[XLEN+1];

  always_ff @(posedge clk) begin
    if (start_i) begin
      rem_q     <= '0;
      quo_q     <= mag_n;
      dvs_q     <= mag_d;
      dvd_q     <= req_i.op1;
      q_neg_q   <= n_neg ^ d_neg;
      r_neg_q   <= n_neg;
      zero_q    <= (req_i.op2 == '0);
      ovf_q     <= sgn & (req_i.op1 == {1'b1, {(XLEN-1){1'b0}}}) & (&req_i.op2);
      rem_sel_q <= req_i.md_type[1];
    end else if (run_q) begin
      quo_q <= {quo_q[XLEN-2:0], ~borrow};
      rem_q <= borrow ? part[XLEN-1:0] : diff[XLEN-1:0];
    end
  end

  assign q_fix = q_neg_q ? -quo_q : quo_q;
  assign r_fix = r_neg_q ? -rem_q : rem_q;

  // riscv defines fixed results for divide by zero and signed overflow
  always_comb begin
    if (zero_q) begin
      result_o = rem_sel_q ? dvd_q : '1;
    end else if (ovf_q) begin
      result_o = rem_sel_q ? '0 : dvd_q;
    end else begin
      result_o = rem_sel_q ? r_fix : q_fix;
    end
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// File: hw/seq_mul.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_cfg.svh"

module seq_mul import exu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            flush_i,
  input  wire logic            start_i,
  input  wire md_req_t         req_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] result_o
);

  localparam int XLEN  = `EXU_XLEN;
  localparam int STEPS = `EXU_MD_STEPS;
  localparam int CW    = $clog2(STEPS + 1);

  logic              sgn_a;
  logic              sgn_b;
  logic              neg_d;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic              run_q;
  logic              done_q;
  logic [CW-1:0]     cnt_q;
  logic              neg_q;
  logic [1:0]        type_q;
  logic [XLEN-1:0]   mcand_q;
  logic [2*XLEN-1:0] acc_q;
  logic [XLEN:0]     part_sum;
  logic [2*XLEN-1:0] prod;

  // mulhu is the only fully unsigned type, mulhsu leaves op2 unsigned
  assign sgn_a = (req_i.md_type != MUL_HUU);
  assign sgn_b = ~req_i.md_type[1];
  assign mag_a = (sgn_a & req_i.op1[XLEN-1]) ? -req_i.op1 : req_i.op1;
  assign mag_b = (sgn_b & req_i.op2[XLEN-1]) ? -req_i.op2 : req_i.op2;
  assign neg_d = (sgn_a & req_i.op1[XLEN-1]) ^ (sgn_b & req_i.op2[XLEN-1]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      run_q  <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (run_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CW'(STEPS - 1)) begin
        run_q  <= 1'b0;
        done_q <= 1'b1;
      end
    end else begin
      done_q <= 1'b0;
    end
  end

  // high half accumulates, low half holds the remaining multiplier bits
  assign part_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk) begin
    if (start_i) begin
      acc_q   <= {{XLEN{1'b0}}, mag_b};
      mcand_q <= mag_a;
      neg_q   <= neg_d;
      type_q  <= req_i.md_type;
    end else if (run_q) begin
      acc_q <= {part_sum, acc_q[XLEN-1:1]};
    end
  end

  assign prod     = neg_q ? -acc_q : acc_q;
  assign result_o = (type_q == MUL_LO) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
  assign done_o   = done_q;

endmodule

`default_nettype wire

// File: hw/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_cfg.svh"

module int_alu import exu_pkg::*; (
  input  wire alu_ctrl_t            ctrl_i,
  input  wire logic [`EXU_XLEN-1:0] src1_i,
  input  wire logic [`EXU_XLEN-1:0] src2_i,
  output logic [`EXU_XLEN-1:0]      result_o,
  output alu_flags_t                flags_o
);

  localparam int XLEN = `EXU_XLEN;
  localparam int SHW  = $clog2(XLEN);

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] val);
    logic [XLEN-1:0] rev;
    for (int i = 0; i < XLEN; i++) begin
      rev[i] = val[XLEN-1-i];
    end
    return rev;
  endfunction

  logic                   sub_en;
  logic [XLEN-1:0]        b_opnd;
  logic [XLEN-1:0]        sum;
  logic                   carry;
  logic                   ovf;
  logic                   less;
  logic                   shl;
  logic [SHW-1:0]         shamt;
  logic [XLEN-1:0]        sh_src;
  logic                   sh_fill;
  logic signed [XLEN:0]   sh_ext;
  logic [XLEN-1:0]        sh_res;
  logic [XLEN-1:0]        alu_out;

  // slt always compares through a subtract
  assign sub_en = ctrl_i.alt | (ctrl_i.func == FUNC_SLT);
  assign b_opnd = src2_i ^ {XLEN{sub_en}};
  assign {carry, sum} = {1'b0, src1_i} + {1'b0, b_opnd} + {{XLEN{1'b0}}, sub_en};

  assign ovf = (src1_i[XLEN-1] == b_opnd[XLEN-1]) & (sum[XLEN-1] != src1_i[XLEN-1]);
  // alt picks unsigned compare, no carry out means borrow
  assign less = ctrl_i.alt ? ~carry : (sum[XLEN-1] ^ ovf);

  // left shifts reuse the right shifter on reversed bits
  assign shl   = (ctrl_i.func == FUNC_SLL);
  assign shamt = ctrl_i.word ? {1'b0, src2_i[4:0]} : src2_i[SHW-1:0];

  always_comb begin
    if (shl) begin
      sh_src = bit_rev(src1_i);
    end else if (ctrl_i.word) begin
      sh_src = {{(XLEN-32){ctrl_i.alt & src1_i[31]}}, src1_i[31:0]};
    end else begin
      sh_src = src1_i;
    end
  end

  assign sh_fill = ~shl & ctrl_i.alt & sh_src[XLEN-1];
  assign sh_ext  = $signed({sh_fill, sh_src}) >>> shamt;
  assign sh_res  = shl ? bit_rev(sh_ext[XLEN-1:0]) : sh_ext[XLEN-1:0];

  always_comb begin
    case (ctrl_i.func)
      FUNC_ADD:  alu_out = sum;
      FUNC_SLL:  alu_out = sh_res;
      FUNC_SLT:  alu_out = {{(XLEN-1){1'b0}}, less};
      FUNC_PASS: alu_out = src2_i;
      FUNC_XOR:  alu_out = src1_i ^ src2_i;
      FUNC_SR:   alu_out = sh_res;
      FUNC_OR:   alu_out = src1_i | src2_i;
      FUNC_AND:  alu_out = src1_i & src2_i;
    endcase
  end

  // word forms return the low half sign-extended
  assign result_o = ctrl_i.word ? {{(XLEN-32){alu_out[31]}}, alu_out[31:0]} : alu_out;

  assign flags_o = '{zero: ~|sum, less: less};

endmodule

`default_nettype wire

// File: hw/exu_pkg.sv
`default_nettype none

`include "exu_cfg.svh"

package exu_pkg;

  // alu func field encodings
  localparam logic [2:0] FUNC_ADD  = 3'b000;
  localparam logic [2:0] FUNC_SLL  = 3'b001;
  localparam logic [2:0] FUNC_SLT  = 3'b010;
  localparam logic [2:0] FUNC_PASS = 3'b011;
  localparam logic [2:0] FUNC_XOR  = 3'b100;
  localparam logic [2:0] FUNC_SR   = 3'b101;
  localparam logic [2:0] FUNC_OR   = 3'b110;
  localparam logic [2:0] FUNC_AND  = 3'b111;

  // multiplier md_type: 00 mul, 01 mulh, 10 mulhsu, 11 mulhu
  // divider md_type: 00 div, 01 divu, 10 rem, 11 remu
  localparam logic [1:0] MUL_LO  = 2'b00;
  localparam logic [1:0] MUL_HUU = 2'b11;

  typedef struct packed {
    logic       word;
    logic       alt;
    logic [2:0] func;
  } alu_ctrl_t;

  typedef struct packed {
    logic       word;
    logic       is_div;
    logic [1:0] md_type;
    logic       rsvd;
  } md_ctrl_t;

  // same control word, decoded per operation class
  typedef union packed {
    alu_ctrl_t alu;
    md_ctrl_t  md;
  } exu_ctrl_u;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [1:0]           md_type;
  } md_req_t;

  typedef struct packed {
    logic zero;
    logic less;
  } alu_flags_t;

endpackage

`default_nettype wire

// File: hw/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// width of operands, results and the engine datapaths
`define EXU_XLEN 64

// one quotient or product bit per cycle, so the engines
// need as many steps as there are operand bits
`define EXU_MD_STEPS `EXU_XLEN

`endif
